//--- design/uart_timing_pkg.sv
package uart_timing_pkg;

    // Oversampling ticks per serial bit
    localparam int OVERSAMPLE = 16;
    localparam int TICK_CNT_W = $clog2(OVERSAMPLE);

    // Tick counter values for the end of a bit and the centre of a bit
    localparam logic [TICK_CNT_W-1:0] LAST_TICK = TICK_CNT_W'(OVERSAMPLE - 1);
    localparam logic [TICK_CNT_W-1:0] MID_TICK = TICK_CNT_W'(OVERSAMPLE / 2 - 1);

    // Clock divisor for the tick generator, covers up to 65535 clocks per tick
    typedef logic [15:0] tick_div_t;

endpackage

//--- design/uart_frame_pkg.sv
package uart_frame_pkg;

    // 8N1 framing
    localparam int DATA_BITS = 8;
    localparam int BIT_IDX_W = $clog2(DATA_BITS);
    localparam logic [BIT_IDX_W-1:0] LAST_BIT = BIT_IDX_W'(DATA_BITS - 1);

    // Line levels
    localparam logic IDLE_LEVEL = 1'b1;
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT = 1'b1;

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // Received byte with its framing status
    typedef struct packed {
        logic       frame_err;
        uart_byte_t data;
    } rx_word_t;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH = 8,
    parameter type T_DATA = logic [7:0]
) (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_wr_en,
    input  T_DATA i_wr_data,
    input  logic  i_rd_en,
    output T_DATA o_rd_data,
    output logic  o_empty,
    output logic  o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    T_DATA            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] next_count;
    logic             do_wr;
    logic             do_rd;

    // Pointers wrap at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
    endfunction

    // Write when full and read when empty are ignored
    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    always_comb begin
        next_count = count;
        if (do_wr && !do_rd) begin
            next_count = count + CNT_W'(1);
        end else if (do_rd && !do_wr) begin
            next_count = count - CNT_W'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_empty <= 1'b1;
            o_full  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= next_count;
            // Flags follow the count one cycle after the access
            o_empty <= (next_count == '0);
            o_full  <= (next_count == FULL_CNT);
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Head word, valid while not empty
    assign o_rd_data = mem[rd_ptr];

endmodule

//--- design/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter uart_timing_pkg::tick_div_t CLKS_PER_TICK = 16'd2
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    import uart_timing_pkg::*;

    localparam tick_div_t RELOAD = CLKS_PER_TICK - tick_div_t'(1);

    tick_div_t cnt;

    // Down-counter, one tick per CLKS_PER_TICK clocks
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt    <= RELOAD;
            o_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt    <= RELOAD;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt - tick_div_t'(1);
            o_tick <= 1'b0;
        end
    end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_tick,
    input  logic                     i_fifo_empty,
    input  uart_frame_pkg::uart_byte_t i_fifo_data,
    output logic                     o_pop,
    output logic                     o_txd,
    output logic                     o_busy
);

    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t             state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    uart_byte_t            shift_reg;
    logic                  txd_q;
    logic                  bit_done;
    logic                  frame_free;

    assign bit_done = i_tick && (tick_cnt == LAST_TICK);

    // A new frame starts from idle or right after the stop bit
    assign frame_free = (state == TX_IDLE && i_tick) || (state == TX_STOP && bit_done);
    assign o_pop      = frame_free && !i_fifo_empty;
    assign o_txd      = txd_q;
    assign o_busy     = (state != TX_IDLE);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd_q    <= IDLE_LEVEL;
        end else if (o_pop) begin
            state    <= TX_START;
            tick_cnt <= '0;
            txd_q    <= START_BIT;
        end else if (i_tick && state != TX_IDLE) begin
            tick_cnt <= (tick_cnt == LAST_TICK) ? '0 : tick_cnt + TICK_CNT_W'(1);
            if (tick_cnt == LAST_TICK) begin
                case (state)
                    TX_START: begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        txd_q   <= shift_reg[0];
                    end
                    TX_DATA: begin
                        if (bit_idx == LAST_BIT) begin
                            state <= TX_STOP;
                            txd_q <= STOP_BIT;
                        end else begin
                            bit_idx <= bit_idx + BIT_IDX_W'(1);
                            txd_q   <= shift_reg[1];
                        end
                    end
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

    // LSB goes out first
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            shift_reg <= i_fifo_data;
        end else if (state == TX_DATA && bit_done && bit_idx != LAST_BIT) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_tick,
    input  logic                     i_rxd,
    output logic                     o_push,
    output uart_frame_pkg::rx_word_t o_word
);

    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state;
    logic                  rxd_meta;
    logic                  rxd_sync;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    uart_byte_t            shift_reg;
    logic                  sample_data;
    logic                  sample_stop;

    // Two-flop synchronizer for the asynchronous line
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rxd_meta <= IDLE_LEVEL;
            rxd_sync <= IDLE_LEVEL;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // Bit centres, counted from the mid-point of the start bit
    assign sample_data = i_tick && state == RX_DATA && tick_cnt == LAST_TICK;
    assign sample_stop = i_tick && state == RX_STOP && tick_cnt == LAST_TICK;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            o_push   <= 1'b0;
        end else begin
            o_push <= sample_stop;
            if (i_tick) begin
                case (state)
                    RX_IDLE: begin
                        if (rxd_sync == START_BIT) begin
                            state    <= RX_START;
                            tick_cnt <= '0;
                        end
                    end
                    RX_START: begin
                        if (tick_cnt == MID_TICK) begin
                            // Line back high at mid-bit means a glitch
                            state    <= (rxd_sync == START_BIT) ? RX_DATA : RX_IDLE;
                            tick_cnt <= '0;
                            bit_idx  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + TICK_CNT_W'(1);
                        end
                    end
                    RX_DATA: begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            bit_idx  <= bit_idx + BIT_IDX_W'(1);
                            if (bit_idx == LAST_BIT) begin
                                state <= RX_STOP;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + TICK_CNT_W'(1);
                        end
                    end
                    default: begin
                        if (tick_cnt == LAST_TICK) begin
                            state    <= RX_IDLE;
                            tick_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + TICK_CNT_W'(1);
                        end
                    end
                endcase
            end
        end
    end

    // Data arrives LSB first, so shift in from the top
    always_ff @(posedge i_clk) begin
        if (sample_data) begin
            shift_reg <= {rxd_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (sample_stop) begin
            o_word.data      <= shift_reg;
            o_word.frame_err <= (rxd_sync != STOP_BIT);
        end
    end

endmodule

//--- design/uart_subsystem.sv
`timescale 1ns/1ps

module uart_subsystem #(
    parameter uart_timing_pkg::tick_div_t CLKS_PER_TICK = 16'd2,
    parameter int                         TX_DEPTH = 8,
    parameter int                         RX_DEPTH = 8
) (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_wr_en,
    input  uart_frame_pkg::uart_byte_t i_wr_data,
    output logic                       o_tx_full,
    output logic                       o_txd,
    output logic                       o_tx_busy,
    input  logic                       i_rxd,
    input  logic                       i_rd_en,
    output uart_frame_pkg::rx_word_t   o_rx_word,
    output logic                       o_rx_empty,
    output logic                       o_rx_full
);

    import uart_frame_pkg::*;

    logic       tick;
    logic       tx_empty;
    logic       tx_pop;
    uart_byte_t tx_head;
    logic       rx_push;
    rx_word_t   rx_word;

    baud_tick_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_tick_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    // Host bytes waiting for the serializer
    sync_fifo #(
        .DEPTH  (TX_DEPTH),
        .T_DATA (uart_byte_t)
    ) u_tx_fifo (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr_en   (i_wr_en),
        .i_wr_data (i_wr_data),
        .i_rd_en   (tx_pop),
        .o_rd_data (tx_head),
        .o_empty   (tx_empty),
        .o_full    (o_tx_full)
    );

    uart_tx u_tx (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_tick       (tick),
        .i_fifo_empty (tx_empty),
        .i_fifo_data  (tx_head),
        .o_pop        (tx_pop),
        .o_txd        (o_txd),
        .o_busy       (o_tx_busy)
    );

    uart_rx u_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rxd   (i_rxd),
        .o_push  (rx_push),
        .o_word  (rx_word)
    );

    // Received words with their framing flag, popped by the host
    sync_fifo #(
        .DEPTH  (RX_DEPTH),
        .T_DATA (rx_word_t)
    ) u_rx_fifo (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr_en   (rx_push),
        .i_wr_data (rx_word),
        .i_rd_en   (i_rd_en),
        .o_rd_data (o_rx_word),
        .o_empty   (o_rx_empty),
        .o_full    (o_rx_full)
    );

endmodule

//--- dv/uart_subsystem_sva.sv
`timescale 1ns/1ps

module uart_subsystem_sva (
    input logic i_clk,
    input logic i_reset,
    input logic tx_wr,
    input logic tx_empty,
    input logic tx_full,
    input logic rx_wr,
    input logic rx_empty,
    input logic rx_full,
    input logic txd,
    input logic tx_busy
);

    // Both FIFOs
    a_tx_flags: assert property (@(posedge i_clk) disable iff (i_reset) !(tx_empty && tx_full))
        else $error("tx FIFO empty and full together");
    a_rx_flags: assert property (@(posedge i_clk) disable iff (i_reset) !(rx_empty && rx_full))
        else $error("rx FIFO empty and full together");
    a_tx_full_rise: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(tx_full) |-> $past(tx_wr))
        else $error("tx FIFO became full without a write");
    a_rx_full_rise: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(rx_full) |-> $past(rx_wr))
        else $error("rx FIFO became full without a write");

    // Serial line rests high between frames
    a_idle_line: assert property (@(posedge i_clk) disable iff (i_reset) !tx_busy |-> txd)
        else $error("txd low while the serializer is idle");

endmodule

bind uart_subsystem uart_subsystem_sva u_sva (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .tx_wr    (i_wr_en),
    .tx_empty (tx_empty),
    .tx_full  (o_tx_full),
    .rx_wr    (rx_push),
    .rx_empty (o_rx_empty),
    .rx_full  (o_rx_full),
    .txd      (o_txd),
    .tx_busy  (o_tx_busy)
);

//--- dv/tb_uart_subsystem.sv
`timescale 1ns/1ps

module tb_uart_subsystem;

    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    localparam int RX_DEPTH = 5;
    localparam int CLKS_PER_BIT = 2 * OVERSAMPLE;
    localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
    localparam int CYCLE_LIMIT = 20 * FRAME_CLKS * 3 + 4000;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic       i_clk;
    logic       i_reset;
    logic       i_wr_en;
    uart_byte_t i_wr_data;
    logic       o_tx_full;
    logic       o_txd;
    logic       o_tx_busy;
    logic       rxd_line;
    logic       i_rd_en;
    rx_word_t   o_rx_word;
    logic       o_rx_empty;
    logic       o_rx_full;

    logic        use_loop;
    logic        drv_rxd;
    logic [31:0] lfsr;
    int          cycle_cnt;
    int          n_value_err;
    int          n_flag_err;
    uart_byte_t  tx_model[$];
    rx_word_t    rx_exp[$];

    uart_subsystem #(
        .CLKS_PER_TICK (16'd2),
        .TX_DEPTH      (6),
        .RX_DEPTH      (RX_DEPTH)
    ) u_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr_en    (i_wr_en),
        .i_wr_data  (i_wr_data),
        .o_tx_full  (o_tx_full),
        .o_txd      (o_txd),
        .o_tx_busy  (o_tx_busy),
        .i_rxd      (rxd_line),
        .i_rd_en    (i_rd_en),
        .o_rx_word  (o_rx_word),
        .o_rx_empty (o_rx_empty),
        .o_rx_full  (o_rx_full)
    );

    // Receive line comes from the serializer or from the frame driver
    assign rxd_line = use_loop ? o_txd : drv_rxd;

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic next_byte(output uart_byte_t b);
        for (int i = 0; i < DATA_BITS; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (exp !== act) begin
            $display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_rx_word(input string name, input rx_word_t exp, input rx_word_t act);
        if (exp !== act) begin
            $display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED t=%0t %s: expected %b, got %b", $time, name, exp, act);
            n_flag_err++;
        end
    endtask

    // Called on a falling edge, the byte counts only if the FIFO has room
    task automatic write_byte(input uart_byte_t b);
        i_wr_en   = 1'b1;
        i_wr_data = b;
        if (!o_tx_full) begin
            tx_model.push_back(b);
        end
        @(negedge i_clk);
        i_wr_en = 1'b0;
    endtask

    task automatic read_check(input rx_word_t exp);
        while (o_rx_empty) begin
            @(negedge i_clk);
        end
        check_rx_word("o_rx_word", exp, o_rx_word);
        i_rd_en = 1'b1;
        @(negedge i_clk);
        i_rd_en = 1'b0;
    endtask

    task automatic wait_tx_idle();
        while (!o_tx_busy) begin
            @(negedge i_clk);
        end
        while (o_tx_busy) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);
    endtask

    task automatic send_frame(input uart_byte_t b, input logic stop);
        drv_rxd = START_BIT;
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        for (int i = 0; i < DATA_BITS; i++) begin
            drv_rxd = b[i];
            repeat (CLKS_PER_BIT) @(negedge i_clk);
        end
        drv_rxd = stop;
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        drv_rxd = IDLE_LEVEL;
        repeat (CLKS_PER_BIT) @(negedge i_clk);
    endtask

    initial begin
        uart_byte_t b;
        uart_byte_t b2;
        logic       saw_full;

        i_clk = 1'b0;
        i_reset = 1'b1;
        i_wr_en = 1'b0;
        i_wr_data = '0;
        i_rd_en = 1'b0;
        use_loop = 1'b1;
        drv_rxd = IDLE_LEVEL;
        lfsr = 32'h8e7c0203;
        cycle_cnt = 0;
        n_value_err = 0;
        n_flag_err = 0;
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);

        check_bit("o_txd", 1'b1, o_txd);
        check_bit("o_tx_busy", 1'b0, o_tx_busy);
        check_bit("o_tx_full", 1'b0, o_tx_full);
        check_bit("o_rx_empty", 1'b1, o_rx_empty);
        check_bit("o_rx_full", 1'b0, o_rx_full);

        // Loopback in groups of three, well below either FIFO depth
        for (int g = 0; g < 4; g++) begin
            for (int i = 0; i < 3; i++) begin
                next_byte(b);
                write_byte(b);
            end
            while (tx_model.size() > 0) begin
                b = tx_model.pop_front();
                read_check('{frame_err: 1'b0, data: b});
            end
        end
        wait_tx_idle();
        check_bit("o_rx_empty", 1'b1, o_rx_empty);

        // Burst of ten writes, some are dropped while full
        saw_full = 1'b0;
        i_wr_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            next_byte(b);
            i_wr_data = b;
            if (o_tx_full) begin
                saw_full = 1'b1;
            end else begin
                tx_model.push_back(b);
            end
            @(negedge i_clk);
        end
        i_wr_en = 1'b0;
        check_bit("o_tx_full seen high", 1'b1, saw_full || o_tx_full);
        while (tx_model.size() > 0) begin
            b = tx_model.pop_front();
            read_check('{frame_err: 1'b0, data: b});
        end
        wait_tx_idle();
        check_bit("o_rx_empty", 1'b1, o_rx_empty);

        // Frame with a low stop bit, then a good frame
        use_loop = 1'b0;
        next_byte(b);
        next_byte(b2);
        send_frame(b, 1'b0);
        send_frame(b2, STOP_BIT);
        while (o_rx_empty) begin
            @(negedge i_clk);
        end
        check_byte("o_rx_word.data", b, o_rx_word.data);
        check_bit("o_rx_word.frame_err", 1'b1, o_rx_word.frame_err);
        i_rd_en = 1'b1;
        @(negedge i_clk);
        i_rd_en = 1'b0;
        while (o_rx_empty) begin
            @(negedge i_clk);
        end
        check_byte("o_rx_word.data", b2, o_rx_word.data);
        check_bit("o_rx_word.frame_err", 1'b0, o_rx_word.frame_err);
        i_rd_en = 1'b1;
        @(negedge i_clk);
        i_rd_en = 1'b0;

        // Seven frames with no reads, the receive FIFO keeps the first five
        use_loop = 1'b1;
        for (int i = 0; i < 7; i++) begin
            while (o_tx_full) begin
                @(negedge i_clk);
            end
            next_byte(b);
            write_byte(b);
        end
        wait_tx_idle();
        while (tx_model.size() > 0) begin
            b = tx_model.pop_front();
            if (rx_exp.size() < RX_DEPTH) begin
                rx_exp.push_back('{frame_err: 1'b0, data: b});
            end
        end
        check_bit("o_rx_full", 1'b1, o_rx_full);
        while (rx_exp.size() > 0) begin
            read_check(rx_exp.pop_front());
        end
        check_bit("o_rx_empty", 1'b1, o_rx_empty);

        $display("Errors: %0d value mismatches, %0d flag mismatches", n_value_err, n_flag_err);
        if (n_value_err == 0 && n_flag_err == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/uart_timing_pkg.sv
design/uart_frame_pkg.sv
design/sync_fifo.sv
design/baud_tick_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_subsystem.sv
dv/uart_subsystem_sva.sv
dv/tb_uart_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_uart_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_uart_subsystem)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1
